/* src/dl1_pkg.sv */
package dl1_pkg;

	// ====================
	// Address and word geometry
	// ====================
	localparam int ADDR_W         = 32;
	localparam int DATA_W         = 32;
	localparam int WORDS_PER_LINE = 4;
	localparam int WORD_SEL_W     = 2;
	localparam int OFFSET_W       = 4;
	localparam int LINE_ADDR_W    = ADDR_W - OFFSET_W;

	// Default organisation
	localparam int DEF_WAYS  = 4;
	localparam int DEF_LINES = 16;

	// ====================
	// Payload types
	// ====================

	// Word 0 sits in the low bits
	typedef logic [WORDS_PER_LINE-1:0][DATA_W-1:0] line_t;

	typedef struct packed
	{
		logic              read;
		logic              write;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} cpu_req_t;

	typedef struct packed
	{
		logic              valid;
		logic [DATA_W-1:0] rdata;
	} cpu_resp_t;

	// Dirty line headed for L2
	typedef struct packed
	{
		logic [LINE_ADDR_W-1:0] line_addr;
		line_t                  line;
	} evict_t;

	// Whole line coming back from L2
	typedef struct packed
	{
		logic  valid;
		line_t line;
	} refill_t;

endpackage

/* src/dl1_sram.sv */
module dl1_sram
#(
	parameter int  LINES   = dl1_pkg::DEF_LINES,
	parameter type entry_t = logic,
	localparam int IDX_W   = $clog2(LINES)
)
(
	input  logic             clk_l1,
	input  logic [IDX_W-1:0] addr,
	input  logic             we,
	input  entry_t           wdata,
	output entry_t           rdata
);

	entry_t mem [LINES];

	// Registered read of the addressed entry, every cycle
	always_ff @(posedge clk_l1)
	begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

/* src/dl1_req_stage.sv */
module dl1_req_stage
#(
	parameter int  LINES = dl1_pkg::DEF_LINES,
	localparam int IDX_W = $clog2(LINES),
	localparam int TAG_W = dl1_pkg::LINE_ADDR_W - IDX_W
)
(
	input  logic                              clk_l1,
	input  logic                              rst_n,
	input  dl1_pkg::cpu_req_t                 cpu_req,
	input  logic                              accept,
	output dl1_pkg::cpu_req_t                 req,
	output logic [TAG_W-1:0]                  tag,
	output logic [IDX_W-1:0]                  index,
	output logic [dl1_pkg::WORD_SEL_W-1:0]    word
);

	// Low address bits below the word select
	localparam int BYTE_W = dl1_pkg::OFFSET_W - dl1_pkg::WORD_SEL_W;

	dl1_pkg::cpu_req_t req_q;

	// ====================
	// Request capture
	// ====================

	// Held for the whole miss sequence
	always_ff @(posedge clk_l1 or negedge rst_n)
	begin
		if (!rst_n)
			req_q <= '0;
		else if (accept)
			req_q <= cpu_req;
	end

	assign req = req_q;

	// ====================
	// Address split
	// ====================

	// Tag is everything above the index
	assign tag = req_q.addr[dl1_pkg::ADDR_W-1 -: TAG_W];

	// Set index just above the line offset
	assign index = req_q.addr[dl1_pkg::OFFSET_W +: IDX_W];

	// Word within the line
	assign word = req_q.addr[BYTE_W +: dl1_pkg::WORD_SEL_W];

endmodule

/* src/dl1_way.sv */
module dl1_way
#(
	parameter int  LINES = dl1_pkg::DEF_LINES,
	localparam int IDX_W = $clog2(LINES),
	localparam int TAG_W = dl1_pkg::LINE_ADDR_W - IDX_W
)
(
	input  logic                           clk_l1,
	input  logic                           rst_n,
	input  dl1_pkg::cpu_req_t              req,
	input  logic [TAG_W-1:0]               tag,
	input  logic [IDX_W-1:0]               index,
	input  logic [dl1_pkg::WORD_SEL_W-1:0] word,
	input  logic                           word_we,
	input  logic                           fill_we,
	input  dl1_pkg::line_t                 fill_line,
	output logic                           hit,
	output logic                           valid,
	output logic                           dirty,
	output logic [TAG_W-1:0]               way_tag,
	output dl1_pkg::line_t                 way_line
);

	logic [LINES-1:0] valid_bits;
	logic [LINES-1:0] dirty_bits;
	logic [TAG_W-1:0] tag_rd;
	dl1_pkg::line_t   line_rd;
	dl1_pkg::line_t   line_merged;
	dl1_pkg::line_t   line_wdata;
	logic             line_we;

	// ====================
	// Storage
	// ====================
	dl1_sram
	#(
		.LINES   (LINES),
		.entry_t (logic [TAG_W-1:0])
	)
	i_tag_ram
	(
		.clk_l1 (clk_l1),
		.addr   (index),
		.we     (fill_we),
		.wdata  (tag),
		.rdata  (tag_rd)
	);

	// Write hit overlays one word on the line just read
	always_comb
	begin
		line_merged       = line_rd;
		line_merged[word] = req.wdata;
	end

	assign line_we    = word_we | fill_we;
	assign line_wdata = fill_we ? fill_line : line_merged;

	dl1_sram
	#(
		.LINES   (LINES),
		.entry_t (dl1_pkg::line_t)
	)
	i_line_ram
	(
		.clk_l1 (clk_l1),
		.addr   (index),
		.we     (line_we),
		.wdata  (line_wdata),
		.rdata  (line_rd)
	);

	// ====================
	// Valid and dirty bits
	// ====================
	always_ff @(posedge clk_l1 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end
		else if (fill_we)
		begin
			valid_bits[index] <= 1'b1;
			dirty_bits[index] <= 1'b0;
		end
		else if (word_we)
			dirty_bits[index] <= 1'b1;
	end

	assign valid = valid_bits[index];
	assign dirty = dirty_bits[index];

	// Tag compare
	assign hit      = valid && (tag_rd == tag);
	assign way_tag  = tag_rd;
	assign way_line = line_rd;

endmodule

/* src/dl1_way_select.sv */
module dl1_way_select
#(
	parameter int  WAYS  = dl1_pkg::DEF_WAYS,
	parameter int  LINES = dl1_pkg::DEF_LINES,
	localparam int IDX_W = $clog2(LINES),
	localparam int TAG_W = dl1_pkg::LINE_ADDR_W - IDX_W
)
(
	input  logic [WAYS-1:0]                hit,
	input  dl1_pkg::line_t                 way_line [WAYS],
	input  logic [TAG_W-1:0]               way_tag  [WAYS],
	input  logic [dl1_pkg::WORD_SEL_W-1:0] word,
	input  logic [IDX_W-1:0]               index,
	input  logic [WAYS-1:0]                victim,
	output logic [dl1_pkg::DATA_W-1:0]     rdata,
	output dl1_pkg::evict_t                evict
);

	dl1_pkg::line_t   hit_line;
	dl1_pkg::line_t   vic_line;
	logic [TAG_W-1:0] vic_tag;

	// ====================
	// Read path
	// ====================

	// Hit vector is one-hot, so an OR of the masked lines is enough
	always_comb
	begin
		hit_line = '0;
		for (int i = 0; i < WAYS; i++)
		begin
			if (hit[i])
				hit_line = hit_line | way_line[i];
		end
	end

	assign rdata = hit_line[word];

	// ====================
	// Write-back path
	// ====================
	always_comb
	begin
		vic_line = '0;
		vic_tag  = '0;
		for (int i = 0; i < WAYS; i++)
		begin
			if (victim[i])
			begin
				vic_line = vic_line | way_line[i];
				vic_tag  = vic_tag | way_tag[i];
			end
		end
	end

	// Line address rebuilt from the victim tag and the current set
	assign evict.line_addr = {vic_tag, index};
	assign evict.line      = vic_line;

endmodule

/* src/dl1_miss_ctrl.sv */
module dl1_miss_ctrl
#(
	parameter int  WAYS  = dl1_pkg::DEF_WAYS,
	parameter int  LINES = dl1_pkg::DEF_LINES,
	localparam int IDX_W = $clog2(LINES),
	localparam int TAG_W = dl1_pkg::LINE_ADDR_W - IDX_W
)
(
	input  logic                            clk_l1,
	input  logic                            rst_n,
	input  dl1_pkg::cpu_req_t               cpu_req,
	input  dl1_pkg::cpu_req_t               req,
	input  logic [WAYS-1:0]                 hit,
	input  logic [WAYS-1:0]                 valid,
	input  logic [WAYS-1:0]                 dirty,
	input  logic [TAG_W-1:0]                tag,
	input  logic [IDX_W-1:0]                index,
	input  logic [dl1_pkg::DATA_W-1:0]      rdata,
	output logic                            accept,
	output logic                            halt,
	output logic [WAYS-1:0]                 word_we,
	output logic [WAYS-1:0]                 fill_we,
	output logic [WAYS-1:0]                 victim,
	output logic                            dirty_req,
	input  logic                            dirty_ack,
	output logic                            refill_req,
	output logic [dl1_pkg::LINE_ADDR_W-1:0] refill_addr,
	input  dl1_pkg::refill_t                refill,
	output dl1_pkg::cpu_resp_t              cpu_resp
);

	typedef enum logic [2:0]
	{
		ST_IDLE,
		ST_READ,
		ST_COMPARE,
		ST_EVICT,
		ST_REFILL
	} state_t;

	state_t          state;
	logic [7:0]      lfsr;
	logic [WAYS-1:0] victim_q;
	logic [WAYS-1:0] victim_next;
	logic            found;
	logic            any_hit;
	logic            in_compare;

	assign any_hit    = |hit;
	assign in_compare = (state == ST_COMPARE);

	// ====================
	// Random replacement source
	// ====================

	// 8-bit Fibonacci LFSR, never reaches zero
	always_ff @(posedge clk_l1 or negedge rst_n)
	begin
		if (!rst_n)
			lfsr <= 8'h01;
		else
			lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
	end

	// Lowest invalid way wins, random way when the set is full
	always_comb
	begin
		victim_next = '0;
		found       = 1'b0;
		for (int i = 0; i < WAYS; i++)
		begin
			if (!valid[i] && !found)
			begin
				victim_next[i] = 1'b1;
				found          = 1'b1;
			end
		end
		if (!found)
			victim_next[int'(lfsr) % WAYS] = 1'b1;
	end

	// ====================
	// Sequencer
	// ====================
	always_ff @(posedge clk_l1 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= ST_IDLE;
			victim_q   <= '0;
			dirty_req  <= 1'b0;
			refill_req <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (accept)
						state <= ST_READ;
				end
				// Storage outputs settle for the held index
				ST_READ:
					state <= ST_COMPARE;
				ST_COMPARE:
				begin
					if (any_hit)
						state <= ST_IDLE;
					else
					begin
						victim_q <= victim_next;
						if (|(victim_next & dirty))
						begin
							state     <= ST_EVICT;
							dirty_req <= 1'b1;
						end
						else
						begin
							state      <= ST_REFILL;
							refill_req <= 1'b1;
						end
					end
				end
				// Write-back must finish before the fetch starts
				ST_EVICT:
				begin
					if (dirty_ack)
					begin
						state      <= ST_REFILL;
						dirty_req  <= 1'b0;
						refill_req <= 1'b1;
					end
				end
				ST_REFILL:
				begin
					if (refill.valid)
					begin
						state      <= ST_READ;
						refill_req <= 1'b0;
						victim_q   <= '0;
					end
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// ====================
	// Outputs
	// ====================
	assign accept = (state == ST_IDLE) && (cpu_req.read || cpu_req.write);
	assign halt   = (state != ST_IDLE);
	assign victim = victim_q;

	// Write hit lands on the edge that closes compare
	assign word_we = hit & {WAYS{in_compare && req.write}};
	assign fill_we = victim_q & {WAYS{(state == ST_REFILL) && refill.valid}};

	assign refill_addr = {tag, index};

	assign cpu_resp.valid = in_compare && any_hit;
	assign cpu_resp.rdata = rdata;

endmodule

/* src/dl1_cache.sv */
module dl1_cache
#(
	parameter int  WAYS  = dl1_pkg::DEF_WAYS,
	parameter int  LINES = dl1_pkg::DEF_LINES,
	localparam int IDX_W = $clog2(LINES),
	localparam int TAG_W = dl1_pkg::LINE_ADDR_W - IDX_W
)
(
	input  logic                            clk_l1,
	input  logic                            rst_n,
	// CPU side
	input  dl1_pkg::cpu_req_t               cpu_req,
	output dl1_pkg::cpu_resp_t              cpu_resp,
	output logic                            halt,
	// Write-back to L2
	output logic                            dirty_req,
	input  logic                            dirty_ack,
	output dl1_pkg::evict_t                 evict,
	// Refill from L2
	output logic                            refill_req,
	output logic [dl1_pkg::LINE_ADDR_W-1:0] refill_addr,
	input  dl1_pkg::refill_t                refill
);

	dl1_pkg::cpu_req_t              req;
	logic [TAG_W-1:0]               tag;
	logic [IDX_W-1:0]               index;
	logic [dl1_pkg::WORD_SEL_W-1:0] word;
	logic                           accept;
	logic [WAYS-1:0]                hit;
	logic [WAYS-1:0]                valid;
	logic [WAYS-1:0]                dirty;
	logic [WAYS-1:0]                word_we;
	logic [WAYS-1:0]                fill_we;
	logic [WAYS-1:0]                victim;
	logic [TAG_W-1:0]               way_tag  [WAYS];
	dl1_pkg::line_t                 way_line [WAYS];
	logic [dl1_pkg::DATA_W-1:0]     rdata;

	// ====================
	// Request stage
	// ====================
	dl1_req_stage #(.LINES(LINES)) i_req_stage
	(
		.clk_l1  (clk_l1),
		.rst_n   (rst_n),
		.cpu_req (cpu_req),
		.accept  (accept),
		.req     (req),
		.tag     (tag),
		.index   (index),
		.word    (word)
	);

	// ====================
	// Ways
	// ====================
	for (genvar w = 0; w < WAYS; w++)
	begin : g_way
		dl1_way #(.LINES(LINES)) i_way
		(
			.clk_l1    (clk_l1),
			.rst_n     (rst_n),
			.req       (req),
			.tag       (tag),
			.index     (index),
			.word      (word),
			.word_we   (word_we[w]),
			.fill_we   (fill_we[w]),
			.fill_line (refill.line),
			.hit       (hit[w]),
			.valid     (valid[w]),
			.dirty     (dirty[w]),
			.way_tag   (way_tag[w]),
			.way_line  (way_line[w])
		);
	end

	dl1_way_select #(.WAYS(WAYS), .LINES(LINES)) i_way_select
	(
		.hit      (hit),
		.way_line (way_line),
		.way_tag  (way_tag),
		.word     (word),
		.index    (index),
		.victim   (victim),
		.rdata    (rdata),
		.evict    (evict)
	);

	// ====================
	// Controller
	// ====================
	dl1_miss_ctrl #(.WAYS(WAYS), .LINES(LINES)) i_miss_ctrl
	(
		.clk_l1      (clk_l1),
		.rst_n       (rst_n),
		.cpu_req     (cpu_req),
		.req         (req),
		.hit         (hit),
		.valid       (valid),
		.dirty       (dirty),
		.tag         (tag),
		.index       (index),
		.rdata       (rdata),
		.accept      (accept),
		.halt        (halt),
		.word_we     (word_we),
		.fill_we     (fill_we),
		.victim      (victim),
		.dirty_req   (dirty_req),
		.dirty_ack   (dirty_ack),
		.refill_req  (refill_req),
		.refill_addr (refill_addr),
		.refill      (refill),
		.cpu_resp    (cpu_resp)
	);

endmodule

/* testbench/dl1_l2_model.sv */
module dl1_l2_model
#(
	parameter int L2_LINES = 1024
)
(
	input  logic                            clk_l1,
	input  logic                            rst_n,
	input  int                              delay,
	input  logic                            dirty_req,
	output logic                            dirty_ack,
	input  dl1_pkg::evict_t                 evict,
	input  logic                            refill_req,
	input  logic [dl1_pkg::LINE_ADDR_W-1:0] refill_addr,
	output dl1_pkg::refill_t                refill,
	output int                              wb_count,
	output int                              refill_count,
	output int                              fault_count,
	output logic [dl1_pkg::LINE_ADDR_W-1:0] last_refill_addr
);

	localparam logic [31:0] SEED  = 32'h0386_e520;
	localparam int          IDX_W = $clog2(L2_LINES);

	dl1_pkg::line_t mem [L2_LINES];
	int             wait_cnt;
	logic [31:0]    rnd;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Only the low line addresses are modeled
	function automatic logic in_range(input logic [dl1_pkg::LINE_ADDR_W-1:0] line_addr);
		return (line_addr >> IDX_W) == 0;
	endfunction

	// ====================
	// Memory image
	// ====================
	initial
	begin
		rnd = SEED;
		for (int i = 0; i < L2_LINES; i++)
		begin
			for (int w = 0; w < dl1_pkg::WORDS_PER_LINE; w++)
			begin
				rnd       = xorshift32(rnd);
				mem[i][w] = rnd;
			end
		end
		dirty_ack        = 1'b0;
		refill           = '0;
		wait_cnt         = 0;
		wb_count         = 0;
		refill_count     = 0;
		fault_count      = 0;
		last_refill_addr = '0;
	end

	// Answers go out on the falling edge after the programmed delay
	always @(negedge clk_l1)
	begin
		dirty_ack    <= 1'b0;
		refill.valid <= 1'b0;
		if (rst_n && dirty_req && !dirty_ack)
		begin
			if (wait_cnt < delay)
				wait_cnt <= wait_cnt + 1;
			else
			begin
				dirty_ack <= 1'b1;
				wait_cnt  <= 0;
			end
		end
		else if (rst_n && refill_req && !refill.valid)
		begin
			if (wait_cnt < delay)
				wait_cnt <= wait_cnt + 1;
			else
			begin
				if (!in_range(refill_addr))
				begin
					$display("L2 model: refill address %h lies outside the modeled memory",
						refill_addr);
					fault_count <= fault_count + 1;
				end
				refill.valid <= 1'b1;
				refill.line  <= mem[refill_addr[IDX_W-1:0]];
				wait_cnt     <= 0;
			end
		end
	end

	// Exchanges complete on the rising edge where the cache samples them
	always @(posedge clk_l1)
	begin
		if (rst_n && dirty_req && dirty_ack)
		begin
			if (!in_range(evict.line_addr))
			begin
				$display("L2 model: write-back address %h lies outside the modeled memory",
					evict.line_addr);
				fault_count <= fault_count + 1;
			end
			mem[evict.line_addr[IDX_W-1:0]] <= evict.line;
			wb_count                        <= wb_count + 1;
		end
		if (rst_n && refill_req && refill.valid)
		begin
			refill_count     <= refill_count + 1;
			last_refill_addr <= refill_addr;
		end
	end

endmodule

/* testbench/tb_dl1_cache.sv */
module tb_dl1_cache;

	localparam int WAYS     = dl1_pkg::DEF_WAYS;
	localparam int L2_LINES = 1024;
	localparam int L2_IDX_W = $clog2(L2_LINES);
	localparam int TIMEOUT  = 200;

	logic                            clk_l1;
	logic                            rst_n;
	dl1_pkg::cpu_req_t               cpu_req;
	dl1_pkg::cpu_resp_t              cpu_resp;
	logic                            halt;
	logic                            dirty_req;
	logic                            dirty_ack;
	dl1_pkg::evict_t                 evict;
	logic                            refill_req;
	logic [dl1_pkg::LINE_ADDR_W-1:0] refill_addr;
	dl1_pkg::refill_t                refill;

	int                              l2_delay;
	int                              wb_count;
	int                              refill_count;
	int                              fault_count;
	logic [dl1_pkg::LINE_ADDR_W-1:0] last_refill_addr;

	// Expected memory contents and the lines the CPU has written
	dl1_pkg::line_t      shadow [L2_LINES];
	logic [L2_LINES-1:0] touched;

	int check_count  = 0;
	int value_errors = 0;
	int other_errors = 0;

	always #10 clk_l1 = ~clk_l1;

	dl1_cache i_dl1_cache
	(
		.clk_l1      (clk_l1),
		.rst_n       (rst_n),
		.cpu_req     (cpu_req),
		.cpu_resp    (cpu_resp),
		.halt        (halt),
		.dirty_req   (dirty_req),
		.dirty_ack   (dirty_ack),
		.evict       (evict),
		.refill_req  (refill_req),
		.refill_addr (refill_addr),
		.refill      (refill)
	);

	dl1_l2_model #(.L2_LINES(L2_LINES)) i_l2
	(
		.clk_l1           (clk_l1),
		.rst_n            (rst_n),
		.delay            (l2_delay),
		.dirty_req        (dirty_req),
		.dirty_ack        (dirty_ack),
		.evict            (evict),
		.refill_req       (refill_req),
		.refill_addr      (refill_addr),
		.refill           (refill),
		.wb_count         (wb_count),
		.refill_count     (refill_count),
		.fault_count      (fault_count),
		.last_refill_addr (last_refill_addr)
	);

	// ====================
	// Helpers
	// ====================
	task automatic check_value(input string what, input logic [127:0] got,
		input logic [127:0] expected);
		check_count++;
		if (got !== expected)
		begin
			value_errors++;
			$display("** Error at time %0t: %s, got %0h, expected %0h", $time, what, got,
				expected);
		end
	endtask

	task automatic report_timeout(input string what);
		other_errors++;
		$display("Timed out waiting for %s at time %0t", what, $time);
	endtask

	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		return shadow[addr[4 +: L2_IDX_W]][addr[3:2]];
	endfunction

	task automatic store_word(input logic [31:0] addr, input logic [31:0] data);
		shadow[addr[4 +: L2_IDX_W]][addr[3:2]] = data;
		touched[addr[4 +: L2_IDX_W]]           = 1'b1;
	endtask

	// Returns on the falling edge right after the accepting edge
	task automatic start_access(input logic is_write, input logic [31:0] addr,
		input logic [31:0] wdata);
		int cycles;
		@(negedge clk_l1);
		cpu_req.read  = !is_write;
		cpu_req.write = is_write;
		cpu_req.addr  = addr;
		cpu_req.wdata = wdata;
		cycles        = 0;
		while (halt && cycles < TIMEOUT)
		begin
			@(negedge clk_l1);
			cycles++;
		end
		if (halt)
			report_timeout("the cache to accept a request");
		@(posedge clk_l1);
		@(negedge clk_l1);
		cpu_req = '0;
	endtask

	// Latency counts falling edges after the accepting edge
	task automatic finish_access(output logic [31:0] rdata, output int latency);
		int cycles;
		cycles = 0;
		rdata  = '0;
		while (!cpu_resp.valid && cycles < TIMEOUT)
		begin
			check_value("halt while busy", halt, 1'b1);
			@(negedge clk_l1);
			cycles++;
		end
		latency = cycles;
		if (!cpu_resp.valid)
			report_timeout("cpu_resp.valid");
		else
		begin
			rdata = cpu_resp.rdata;
			@(negedge clk_l1);
			check_value("response pulse lasts one cycle", cpu_resp.valid, 1'b0);
		end
	endtask

	task automatic cpu_access(input logic is_write, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output int latency);
		start_access(is_write, addr, wdata);
		finish_access(rdata, latency);
	endtask

	// Every write-back must match what the CPU last wrote to that line
	always @(posedge clk_l1)
	begin
		if (rst_n && dirty_req && dirty_ack)
		begin
			check_value("write-back of a line the CPU wrote",
				touched[evict.line_addr[L2_IDX_W-1:0]], 1'b1);
			check_value("write-back line data", evict.line,
				shadow[evict.line_addr[L2_IDX_W-1:0]]);
		end
	end

	// ====================
	// Directed tests
	// ====================
	task automatic test_reset();
		@(negedge clk_l1);
		check_value("halt after reset", halt, 1'b0);
		check_value("dirty_req after reset", dirty_req, 1'b0);
		check_value("refill_req after reset", refill_req, 1'b0);
		check_value("cpu_resp.valid after reset", cpu_resp.valid, 1'b0);
	endtask

	task automatic test_read_miss_then_hit();
		logic [31:0] data;
		int          latency;
		int          refills_before;
		refills_before = refill_count;
		cpu_access(1'b0, 32'h0000_0120, '0, data, latency);
		check_value("refills after read miss", refill_count, refills_before + 1);
		check_value("refill line address", last_refill_addr, 28'h000_0012);
		check_value("read miss data", data, expected_word(32'h0000_0120));
		cpu_access(1'b0, 32'h0000_0124, '0, data, latency);
		check_value("refills after read hit", refill_count, refills_before + 1);
		check_value("read hit latency", latency, 1);
		check_value("read hit data", data, expected_word(32'h0000_0124));
	endtask

	task automatic test_write_hit_read_back();
		logic [31:0] data;
		int          latency;
		int          refills_before;
		int          wb_before;
		refills_before = refill_count;
		wb_before      = wb_count;
		cpu_access(1'b1, 32'h0000_0128, 32'hc0de_0128, data, latency);
		store_word(32'h0000_0128, 32'hc0de_0128);
		check_value("write hit latency", latency, 1);
		for (int w = 0; w < dl1_pkg::WORDS_PER_LINE; w++)
		begin
			cpu_access(1'b0, 32'h0000_0120 + 4 * w, '0, data, latency);
			check_value("read back after write hit", data, expected_word(32'h0000_0120 + 4 * w));
		end
		check_value("refills during write hit test", refill_count, refills_before);
		check_value("write-backs during write hit test", wb_count, wb_before);
	endtask

	task automatic test_conflict_eviction();
		logic [31:0] data;
		logic [31:0] addr;
		int          latency;
		int          wb_before;
		wb_before = wb_count;
		// Set 5, one distinct tag per line
		for (int k = 1; k <= WAYS + 2; k++)
		begin
			addr = (k << 8) | 32'h50 | ((k % 4) << 2);
			cpu_access(1'b1, addr, 32'hbeef_0000 | k, data, latency);
			store_word(addr, 32'hbeef_0000 | k);
		end
		for (int k = 1; k <= WAYS + 2; k++)
		begin
			addr = (k << 8) | 32'h50 | ((k % 4) << 2);
			cpu_access(1'b0, addr, '0, data, latency);
			check_value("conflict read of written word", data, expected_word(addr));
			addr = (k << 8) | 32'h50 | (((k + 1) % 4) << 2);
			cpu_access(1'b0, addr, '0, data, latency);
			check_value("conflict read of neighbour word", data, expected_word(addr));
		end
		check_value("dirty evictions happened", (wb_count - wb_before) >= 2, 1'b1);
	endtask

	task automatic test_back_pressure();
		logic [31:0] data;
		int          latency;
		int          cycles;
		int          stalled;
		l2_delay = 24;
		start_access(1'b0, 32'h0000_0234, '0);
		cycles = 0;
		while (!refill_req && cycles < TIMEOUT)
		begin
			@(negedge clk_l1);
			cycles++;
		end
		if (!refill_req)
			report_timeout("refill_req under back-pressure");
		stalled = 0;
		while (refill_req && stalled < TIMEOUT)
		begin
			check_value("halt during refill stall", halt, 1'b1);
			check_value("no response during refill stall", cpu_resp.valid, 1'b0);
			@(negedge clk_l1);
			stalled++;
		end
		check_value("refill_req held through the L2 delay", stalled >= l2_delay, 1'b1);
		finish_access(data, latency);
		check_value("read data after back-pressure", data, expected_word(32'h0000_0234));
		l2_delay = 2;
	endtask

	initial
	begin
		clk_l1   = 1'b0;
		rst_n    = 1'b0;
		cpu_req  = '0;
		l2_delay = 2;
		touched  = '0;
		repeat (16) @(negedge clk_l1);
		rst_n = 1'b1;
		for (int i = 0; i < L2_LINES; i++)
			shadow[i] = i_l2.mem[i];
		test_reset();
		test_read_miss_then_hit();
		test_write_hit_read_back();
		test_conflict_eviction();
		test_back_pressure();
		$display("Checks: %0d, value errors: %0d, other errors: %0d", check_count,
			value_errors, other_errors + fault_count);
		if (value_errors == 0 && other_errors == 0 && fault_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* src.f */
src/dl1_pkg.sv
src/dl1_sram.sv
src/dl1_req_stage.sv
src/dl1_way.sv
src/dl1_way_select.sv
src/dl1_miss_ctrl.sv
src/dl1_cache.sv
testbench/dl1_l2_model.sv
testbench/tb_dl1_cache.sv
